/* verilog.f */
rtl/decodePkg.sv
rtl/pipeSlot.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/operandForward.sv
rtl/branchUnit.sv
rtl/decodeStage.sv
sim/tbClock.sv
sim/decodeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f verilog.f --top-module decodeStageTb

./obj_dir/VdecodeStageTb

/* sim/decodeStageTb.sv */
/* Decode stage testbench. Registers r1-r7 are preloaded through wbIn, then a
   table of instructions is pushed under random issue back-pressure.
   Rows that use forwarding only enter an empty pipeline. */
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb
	import decodePkg::*;
();

	localparam int periodNs    = 100;
	localparam int resetCycles = 16;
	localparam int numRows     = 27;
	localparam int watchdogCycles = numRows * 20 + resetCycles + 16;
	localparam logic [31:0] seed = 32'hc69d_1e5f;
	localparam regWrite_t noFwd = '0;

	typedef struct {
		word_t        pc;
		word_t        instr;
		regWrite_t    exe;
		regWrite_t    mem;
		regWrite_t    wb;
		issuePacket_t want;
	} stimRow_t;

	logic         CLK, RESET;
	logic         fetchValid, fetchReady, issueValid, issueReady;
	fetchPacket_t fetchIn;
	regWrite_t    exeFwd, memFwd, wbIn;
	issuePacket_t issueOut;
	stimRow_t     rows [numRows];
	int           rowCount;

	tbClock #(.periodNs(periodNs), .resetCycles(resetCycles)) clockGen (.CLK(CLK), .RESET(RESET));

	decodeStage dut (
		.CLK(CLK), .RESET(RESET),
		.fetchValid(fetchValid), .fetchReady(fetchReady), .fetchIn(fetchIn),
		.exeFwd(exeFwd), .memFwd(memFwd), .wbIn(wbIn),
		.issueValid(issueValid), .issueReady(issueReady), .issueOut(issueOut)
	);

	////////////////////////////////////////////////////////////////////////////
	// Encoders and expected control words

	function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd, logic [4:0] sh,
			logic [5:0] fn);
		return {opSpecial, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iType(logic [5:0] op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(logic [5:0] op, logic [25:0] index);
		return {op, index};
	endfunction

	function automatic regWrite_t fwd(regAddr_t addr, logic on, word_t data);
		return '{enable: on, addr: addr, data: data};
	endfunction

	function automatic decodeCtrl_t aluCtrl(aluOp_t op, logic useImm, logic sext, logic toRd);
		decodeCtrl_t c;
		c = '0;
		c.memSize    = memWord;
		c.aluOp      = op;
		c.regWrite   = 1'b1;
		c.aluSrcImm  = useImm;
		c.signExtImm = sext;
		c.destIsRd   = toRd;
		return c;
	endfunction

	function automatic decodeCtrl_t memCtrl(logic load, memSize_t size, logic uns);
		decodeCtrl_t c;
		c = '0;
		c.aluOp       = aluAddu;  // Base plus offset
		c.regWrite    = load;
		c.memRead     = load;
		c.memWrite    = !load;
		c.memSize     = size;
		c.memUnsigned = uns;
		c.aluSrcImm   = 1'b1;
		c.signExtImm  = 1'b1;
		return c;
	endfunction

	function automatic decodeCtrl_t branchCtrl(brCond_t cond);
		decodeCtrl_t c;
		c = '0;
		c.memSize    = memWord;
		c.signExtImm = 1'b1;
		c.brCond     = cond;
		return c;
	endfunction

	function automatic decodeCtrl_t jumpCtrl(logic viaReg, logic linkIt);
		decodeCtrl_t c;
		c = '0;
		c.memSize  = memWord;
		c.aluOp    = linkIt ? aluAddu : aluAdd;  // Link value is pc+4 plus 4
		c.regWrite = linkIt;
		c.destIsRd = viaReg && linkIt;           // JALR names rd
		c.jump     = 1'b1;
		c.jumpReg  = viaReg;
		c.link     = linkIt;
		return c;
	endfunction

	function automatic decodeCtrl_t illegalCtrl();
		decodeCtrl_t c;
		c = '0;
		c.illegal = 1'b1;
		return c;
	endfunction

	function automatic logic [31:0] lcgNext(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic needsForward(int i);
		return rows[i].exe.enable || rows[i].mem.enable || rows[i].wb.enable;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	// Preload r1=11 r2=22 r3=fffffff0 r4=11 r5=5 r6=80000000 r7=12345678

	task automatic addRow(word_t pc, word_t instr, regWrite_t exe, regWrite_t mem,
			decodeCtrl_t ctrl, word_t a, word_t b, word_t store, regAddr_t dest,
			logic taken, word_t next);
		rows[rowCount].pc    = pc;
		rows[rowCount].instr = instr;
		rows[rowCount].exe   = exe;
		rows[rowCount].mem   = mem;
		rows[rowCount].wb    = noFwd;
		rows[rowCount].want  = '{pc: pc, ctrl: ctrl, operandA: a, operandB: b, storeData: store,
			destReg: dest, shamt: instr[10:6], takenBranch: taken, nextPc: next};
		rowCount++;
	endtask

	task automatic loadTable();
		decodeCtrl_t c;
		rowCount = 0;
		c = aluCtrl(aluSltu, 1'b1, 1'b1, 1'b0);
		c.regWrite = 1'b0;  // Destination r0
		addRow(32'h0040_0000, rType(5'd1, 5'd2, 5'd8, 5'd0, fnAddu), noFwd, noFwd,
			aluCtrl(aluAddu, 1'b0, 1'b0, 1'b1), 32'h11, 32'h22, 32'h22, 5'd8, 1'b0, 32'h0040_0004);
		addRow(32'h0040_0004, rType(5'd7, 5'd3, 5'd9, 5'd0, fnSub), noFwd, noFwd,
			aluCtrl(aluSub, 1'b0, 1'b0, 1'b1), 32'h1234_5678, 32'hffff_fff0, 32'hffff_fff0, 5'd9,
			1'b0, 32'h0040_0008);
		addRow(32'h0040_0008, rType(5'd0, 5'd6, 5'd10, 5'd4, fnSra), noFwd, noFwd,
			aluCtrl(aluSra, 1'b0, 1'b0, 1'b1), 32'h0, 32'h8000_0000, 32'h8000_0000, 5'd10,
			1'b0, 32'h0040_000c);
		addRow(32'h0040_000c, iType(opAddi, 5'd1, 5'd12, 16'hfff8), noFwd, noFwd,
			aluCtrl(aluAdd, 1'b1, 1'b1, 1'b0), 32'h11, 32'hffff_fff8, 32'h0, 5'd12, 1'b0, 32'h0040_0010);
		addRow(32'h0040_0010, iType(opOri, 5'd7, 5'd13, 16'h8001), noFwd, noFwd,
			aluCtrl(aluOr, 1'b1, 1'b0, 1'b0), 32'h1234_5678, 32'h8001, 32'h0, 5'd13, 1'b0, 32'h0040_0014);
		addRow(32'h0040_0014, iType(opLui, 5'd0, 5'd14, 16'hbeef), noFwd, noFwd,
			aluCtrl(aluLui, 1'b1, 1'b0, 1'b0), 32'h0, 32'hbeef, 32'h0, 5'd14, 1'b0, 32'h0040_0018);
		addRow(32'h0040_0018, iType(opSltiu, 5'd1, 5'd0, 16'h0005), noFwd, noFwd,
			c, 32'h11, 32'h5, 32'h0, 5'd0, 1'b0, 32'h0040_001c);
		// Forwarding rows
		addRow(32'h0040_001c, rType(5'd1, 5'd2, 5'd15, 5'd0, fnAddu),
			fwd(5'd1, 1'b1, 32'haaaa_0001), fwd(5'd1, 1'b1, 32'hbbbb_0001),
			aluCtrl(aluAddu, 1'b0, 1'b0, 1'b1), 32'haaaa_0001, 32'h22, 32'h22, 5'd15, 1'b0, 32'h0040_0020);
		addRow(32'h0040_0020, rType(5'd1, 5'd2, 5'd15, 5'd0, fnAddu),
			fwd(5'd1, 1'b0, 32'hcccc_0001), fwd(5'd1, 1'b1, 32'hdddd_0001),
			aluCtrl(aluAddu, 1'b0, 1'b0, 1'b1), 32'hdddd_0001, 32'h22, 32'h22, 5'd15, 1'b0, 32'h0040_0024);
		addRow(32'h0040_0024, rType(5'd0, 5'd2, 5'd16, 5'd0, fnAddu),
			fwd(5'd0, 1'b1, 32'heeee_0000), fwd(5'd2, 1'b1, 32'hffff_0002),
			aluCtrl(aluAddu, 1'b0, 1'b0, 1'b1), 32'h0, 32'hffff_0002, 32'hffff_0002, 5'd16,
			1'b0, 32'h0040_0028);
		addRow(32'h0040_0028, iType(opSw, 5'd1, 5'd2, 16'h0008), noFwd, fwd(5'd2, 1'b1, 32'h5a5a_5a5a),
			memCtrl(1'b0, memWord, 1'b0), 32'h11, 32'h8, 32'h5a5a_5a5a, 5'd2, 1'b0, 32'h0040_002c);
		// Loads and stores
		addRow(32'h0040_002c, iType(opLb, 5'd7, 5'd17, 16'hfffc), noFwd, noFwd,
			memCtrl(1'b1, memByte, 1'b0), 32'h1234_5678, 32'hffff_fffc, 32'h0, 5'd17,
			1'b0, 32'h0040_0030);
		addRow(32'h0040_0030, iType(opLhu, 5'd1, 5'd18, 16'h0002), noFwd, noFwd,
			memCtrl(1'b1, memHalf, 1'b1), 32'h11, 32'h2, 32'h0, 5'd18, 1'b0, 32'h0040_0034);
		addRow(32'h0040_0034, iType(opSb, 5'd2, 5'd3, 16'h7fff), noFwd, noFwd,
			memCtrl(1'b0, memByte, 1'b0), 32'h22, 32'h7fff, 32'hffff_fff0, 5'd3, 1'b0, 32'h0040_0038);
		// Branches
		addRow(32'h0040_0038, iType(opBeq, 5'd1, 5'd4, 16'h0003), noFwd, noFwd,
			branchCtrl(brEq), 32'h11, 32'h11, 32'h11, 5'd4, 1'b1, 32'h0040_0048);
		addRow(32'h0040_003c, iType(opBne, 5'd1, 5'd4, 16'hfffe), noFwd, noFwd,
			branchCtrl(brNe), 32'h11, 32'h11, 32'h11, 5'd4, 1'b0, 32'h0040_0040);
		addRow(32'h0040_0040, iType(opBlez, 5'd3, 5'd0, 16'h0010), noFwd, noFwd,
			branchCtrl(brLez), 32'hffff_fff0, 32'h0, 32'h0, 5'd0, 1'b1, 32'h0040_0084);
		addRow(32'h0040_0044, iType(opBgtz, 5'd5, 5'd0, 16'hffff), noFwd, noFwd,
			branchCtrl(brGtz), 32'h5, 32'h0, 32'h0, 5'd0, 1'b1, 32'h0040_0044);
		addRow(32'h0040_0048, iType(opRegImm, 5'd6, rtBltz, 16'h0020), noFwd, noFwd,
			branchCtrl(brLtz), 32'h8000_0000, 32'h0, 32'h0, 5'd0, 1'b1, 32'h0040_00cc);
		addRow(32'h0040_004c, iType(opRegImm, 5'd3, rtBgez, 16'h0020), noFwd, noFwd,
			branchCtrl(brGez), 32'hffff_fff0, 32'h11, 32'h11, 5'd1, 1'b0, 32'h0040_0050);
		// The J row checks the upper bits of pc+4
		addRow(32'h8fff_fffc, jType(opJ, 26'h000_0400), noFwd, noFwd,
			jumpCtrl(1'b0, 1'b0), 32'h0, 32'h0, 32'h0, 5'd0, 1'b1, 32'h9000_1000);
		addRow(32'h0040_0050, jType(opJal, 26'h000_0040), noFwd, noFwd,
			jumpCtrl(1'b0, 1'b1), 32'h0040_0054, 32'h4, 32'h0, linkReg, 1'b1, 32'h0000_0100);
		addRow(32'h0040_0054, rType(5'd7, 5'd0, 5'd0, 5'd0, fnJr), noFwd, noFwd,
			jumpCtrl(1'b1, 1'b0), 32'h1234_5678, 32'h0, 32'h0, 5'd0, 1'b1, 32'h1234_5678);
		addRow(32'h0040_0058, rType(5'd2, 5'd0, 5'd19, 5'd0, fnJalr),
			fwd(5'd2, 1'b1, 32'h0040_2000), fwd(5'd2, 1'b1, 32'h1111_2222),
			jumpCtrl(1'b1, 1'b1), 32'h0040_005c, 32'h4, 32'h0, 5'd19, 1'b1, 32'h0040_2000);
		// Unknown opcode and unknown funct
		addRow(32'h0040_005c, iType(6'h3f, 5'd1, 5'd2, 16'h1234), noFwd, noFwd,
			illegalCtrl(), 32'h11, 32'h22, 32'h22, 5'd2, 1'b0, 32'h0040_0060);
		addRow(32'h0040_0060, rType(5'd1, 5'd2, 5'd20, 5'd0, 6'h01), noFwd, noFwd,
			illegalCtrl(), 32'h11, 32'h22, 32'h22, 5'd2, 1'b0, 32'h0040_0064);
		// Memory beats writeback; last row since the writeback also lands in r2
		addRow(32'h0040_0064, rType(5'd21, 5'd2, 5'd23, 5'd0, fnAddu), noFwd,
			fwd(5'd2, 1'b1, 32'h3333_0002),
			aluCtrl(aluAddu, 1'b0, 1'b0, 1'b1), 32'h0, 32'h3333_0002, 32'h3333_0002, 5'd23,
			1'b0, 32'h0040_0068);
		rows[rowCount-1].wb = fwd(5'd2, 1'b1, 32'h4444_0002);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks

	task automatic stopWithFailure();
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkCtrl(int row, decodeCtrl_t got, decodeCtrl_t exp);
		if (got !== exp) begin
			$display("Fail issueOut.ctrl row %0d: got %h expected %h", row, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkPacket(int row, issuePacket_t got, issuePacket_t exp);
		checkCtrl(row, got.ctrl, exp.ctrl);
		if (got !== exp) begin
			$display("Fail issueOut row %0d: got %h expected %h", row, got, exp);
			stopWithFailure();
		end
	endtask

	initial begin : watchdog
		#(watchdogCycles * periodNs);
		$display("Timeout: not every table row was issued in the allowed time");
		stopWithFailure();
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin : stimulus
		logic [31:0]  rng;
		word_t        regInit [7];
		int           sent, issued, holdRow;
		logic         fetchFire, issueFire;
		issuePacket_t seen;

		fetchValid = 1'b0;
		fetchIn    = '0;
		exeFwd     = noFwd;
		memFwd     = noFwd;
		wbIn       = noFwd;
		issueReady = 1'b0;
		rng        = seed;
		regInit    = '{32'h11, 32'h22, 32'hffff_fff0, 32'h11, 32'h5, 32'h8000_0000, 32'h1234_5678};
		loadTable();
		if (rowCount != numRows) begin
			$display("The stimulus table holds %0d rows instead of %0d", rowCount, numRows);
			stopWithFailure();
		end

		@(posedge RESET);
		@(negedge CLK);
		#(periodNs / 4);
		checkFlag("issueValid", issueValid, 1'b0);
		checkFlag("fetchReady", fetchReady, 1'b1);

		for (int r = 1; r <= 7; r++) begin
			@(negedge CLK);
			wbIn = '{enable: 1'b1, addr: 5'(r), data: regInit[r-1]};
		end
		@(negedge CLK);
		wbIn = noFwd;

		sent      = 0;
		issued    = 0;
		holdRow   = -1;  // Row whose forward inputs are held
		fetchFire = 1'b0;
		issueFire = 1'b0;
		seen      = '0;
		while (issued < numRows) begin
			@(negedge CLK);
			if (fetchFire) begin
				sent++;
			end
			if (issueFire) begin
				checkPacket(issued, seen, rows[issued].want);
				if (issued == holdRow) begin
					holdRow = -1;
				end
				issued++;
			end

			rng        = lcgNext(rng);
			issueReady = (rng[31:30] != 2'b00);  // Ready about three cycles in four
			fetchValid = 1'b0;
			if (sent < numRows && (holdRow < 0 || holdRow == sent)) begin
				if (!needsForward(sent) || sent == issued) begin
					fetchValid    = 1'b1;
					fetchIn.pc    = rows[sent].pc;
					fetchIn.instr = rows[sent].instr;
					if (needsForward(sent)) begin
						holdRow = sent;
					end
				end
			end
			if (holdRow >= 0) begin
				exeFwd = rows[holdRow].exe;
				memFwd = rows[holdRow].mem;
				wbIn   = rows[holdRow].wb;
			end else begin
				exeFwd = noFwd;
				memFwd = noFwd;
				wbIn   = noFwd;
			end

			// Handshake inputs are settled until the next rising edge
			#(periodNs / 4);
			fetchFire = fetchValid && fetchReady;
			issueFire = issueValid && issueReady;
			seen      = issueOut;
		end

		// Nothing may issue beyond the table
		repeat (4) begin
			@(negedge CLK);
			fetchValid = 1'b0;
			issueReady = 1'b1;
			#(periodNs / 4);
			if (issueValid) begin
				$display("An extra packet was issued after the last table row");
				stopWithFailure();
			end
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tbClock.sv */
/* Testbench clock and active-low reset. RESET is released on a falling
   edge after resetCycles rising edges. */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 16
) (
	output logic CLK,
	output logic RESET
);

	initial begin
		CLK = 1'b0;
		forever #(periodNs / 2) CLK = ~CLK;
	end

	initial begin
		RESET = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		@(negedge CLK);  // Release away from the active edge
		RESET = 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
/* Decode stage top. Two slots deep: fetch slot feeds the combinational decode,
   operands are captured when the instruction moves into the issue slot. */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
	import decodePkg::*;
(
	input  logic         CLK,
	input  logic         RESET,
	input  logic         fetchValid,
	output logic         fetchReady,
	input  fetchPacket_t fetchIn,
	input  regWrite_t    exeFwd,
	input  regWrite_t    memFwd,
	input  regWrite_t    wbIn,
	output logic         issueValid,
	input  logic         issueReady,
	output issuePacket_t issueOut
);

	fetchPacket_t curFetch;
	logic         curValid;
	logic         issueSlotReady;
	decodeCtrl_t  ctrl;
	decodeCtrl_t  issueCtrl;
	regAddr_t     rs, rt, rd;
	regAddr_t     destReg;
	word_t        fileA, fileB;
	word_t        valueA, valueB;
	word_t        operandA, operandB;
	word_t        nextPc;
	logic         takenBranch;
	issuePacket_t nextIssue;

	////////////////////////////////////////////////////////////////////////////
	// Input side
	pipeSlot #(.payload_t(fetchPacket_t)) fetchSlot (
		.CLK(CLK), .RESET(RESET),
		.inValid(fetchValid), .inReady(fetchReady), .inData(fetchIn),
		.outValid(curValid), .outReady(issueSlotReady), .outData(curFetch)
	);

	assign rs = curFetch.instr[25:21];
	assign rt = curFetch.instr[20:16];
	assign rd = curFetch.instr[15:11];

	////////////////////////////////////////////////////////////////////////////
	// Decode, read and resolve
	controlDecoder decoder (.instr(curFetch.instr), .ctrl(ctrl));

	registerFile regFile (
		.CLK(CLK), .RESET(RESET),
		.readAddrA(rs), .readAddrB(rt), .readDataA(fileA), .readDataB(fileB),
		.wb(wbIn)
	);

	operandForward bypass (
		.rs(rs), .rt(rt), .fileA(fileA), .fileB(fileB),
		.exeFwd(exeFwd), .memFwd(memFwd), .wbFwd(wbIn),
		.valueA(valueA), .valueB(valueB)
	);

	branchUnit branch (
		.pc(curFetch.pc), .instr(curFetch.instr), .ctrl(ctrl),
		.valueA(valueA), .valueB(valueB), .immValue(),
		.operandA(operandA), .operandB(operandB),
		.takenBranch(takenBranch), .nextPc(nextPc)
	);

	// JAL is the only link without destIsRd
	assign destReg = ctrl.destIsRd ? rd : (ctrl.link ? linkReg : rt);

	always_comb begin
		issueCtrl          = ctrl;
		issueCtrl.regWrite = ctrl.regWrite && (destReg != '0);  // r0 writes dropped
	end

	assign nextIssue = '{
		pc:          curFetch.pc,
		ctrl:        issueCtrl,
		operandA:    operandA,
		operandB:    operandB,
		storeData:   valueB,
		destReg:     destReg,
		shamt:       curFetch.instr[10:6],
		takenBranch: takenBranch,
		nextPc:      nextPc
	};

	////////////////////////////////////////////////////////////////////////////
	// Output side
	pipeSlot #(.payload_t(issuePacket_t)) issueSlot (
		.CLK(CLK), .RESET(RESET),
		.inValid(curValid), .inReady(issueSlotReady), .inData(nextIssue),
		.outValid(issueValid), .outReady(issueReady), .outData(issueOut)
	);

endmodule

`default_nettype wire

/* rtl/branchUnit.sv */
/* Immediate build, branch compare and next-PC select, no delay slot modelled.
   takenBranch flags any redirect, so jumps raise it too. */
`timescale 1ns/1ps
`default_nettype none

module branchUnit
	import decodePkg::*;
(
	input  word_t       pc,
	input  word_t       instr,
	input  decodeCtrl_t ctrl,
	input  word_t       valueA,
	input  word_t       valueB,
	output word_t       immValue,
	output word_t       operandA,
	output word_t       operandB,
	output logic        takenBranch,
	output word_t       nextPc
);

	word_t pcPlus4;
	word_t branchTarget;
	word_t jumpTarget;
	logic  aZero;
	logic  condMet;

	assign pcPlus4  = pc + 32'd4;
	assign immValue = ctrl.signExtImm ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

	assign branchTarget = pcPlus4 + {immValue[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};  // Region of the delay slot

	assign aZero = (valueA == '0);

	always_comb begin
		case (ctrl.brCond)
			brEq:    condMet = (valueA == valueB);
			brNe:    condMet = (valueA != valueB);
			brLez:   condMet = valueA[31] || aZero;
			brGtz:   condMet = !valueA[31] && !aZero;
			brLtz:   condMet = valueA[31];
			brGez:   condMet = !valueA[31];
			default: condMet = 1'b0;
		endcase
	end

	assign takenBranch = ctrl.jump || condMet;

	always_comb begin
		if (ctrl.jump && ctrl.jumpReg) begin
			nextPc = valueA;        // JR/JALR
		end else if (ctrl.jump) begin
			nextPc = jumpTarget;    // J/JAL
		end else if (condMet) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	// Link writes return address as pc+4 plus 4 through the adder
	assign operandA = ctrl.link ? pcPlus4 : valueA;
	assign operandB = ctrl.link ? 32'd4 : (ctrl.aluSrcImm ? immValue : valueB);

endmodule

`default_nettype wire

/* rtl/operandForward.sv */
/* Operand bypass for rs and rt. Newest producer wins: execute, then memory,
   then writeback, then the register file. Writes aimed at r0 never match. */
`timescale 1ns/1ps
`default_nettype none

module operandForward
	import decodePkg::*;
(
	input  regAddr_t  rs,
	input  regAddr_t  rt,
	input  word_t     fileA,
	input  word_t     fileB,
	input  regWrite_t exeFwd,
	input  regWrite_t memFwd,
	input  regWrite_t wbFwd,
	output word_t     valueA,
	output word_t     valueB
);

	function automatic logic srcHit(regWrite_t src, regAddr_t operand);
		return src.enable && (src.addr == operand) && (operand != '0);
	endfunction

	function automatic word_t pickNewest(regAddr_t operand, word_t fileVal,
			regWrite_t exe, regWrite_t mem, regWrite_t wb);
		word_t result;
		if (srcHit(exe, operand)) begin
			result = exe.data;
		end else if (srcHit(mem, operand)) begin
			result = mem.data;
		end else if (srcHit(wb, operand)) begin
			result = wb.data;  // File not yet written this cycle
		end else begin
			result = fileVal;
		end
		return result;
	endfunction

	assign valueA = pickNewest(rs, fileA, exeFwd, memFwd, wbFwd);
	assign valueB = pickNewest(rt, fileB, exeFwd, memFwd, wbFwd);

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
/* 32 x 32 register file, two combinational reads and one write on CLK.
   A write shows on the read ports one cycle later; same-cycle reads need forwarding. */
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import decodePkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  regAddr_t  readAddrA,
	input  regAddr_t  readAddrB,
	output word_t     readDataA,
	output word_t     readDataB,
	input  regWrite_t wb
);

	word_t regs [numRegs];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.enable && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// r0 is hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* rtl/controlDecoder.sv */
/* Integer MIPS control decode. Anything outside the kept subset comes out
   with only illegal set, so it travels down the pipe as a no-op. */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
	import decodePkg::*;
(
	input  word_t       instr,
	output decodeCtrl_t ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rtField;
	logic       unknown;

	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign rtField = instr[20:16];

	always_comb begin
		ctrl         = '0;
		ctrl.memSize = memWord;
		unknown      = 1'b0;

		case (opcode)
			opSpecial: begin
				ctrl.regWrite = 1'b1;
				ctrl.destIsRd = 1'b1;
				case (funct)
					fnSll:  ctrl.aluOp = aluSll;   // Shift amount in shamt
					fnSrl:  ctrl.aluOp = aluSrl;
					fnSra:  ctrl.aluOp = aluSra;
					fnSllv: ctrl.aluOp = aluSllv;
					fnSrlv: ctrl.aluOp = aluSrlv;
					fnSrav: ctrl.aluOp = aluSrav;
					fnAdd:  ctrl.aluOp = aluAdd;
					fnAddu: ctrl.aluOp = aluAddu;
					fnSub:  ctrl.aluOp = aluSub;
					fnSubu: ctrl.aluOp = aluSubu;
					fnAnd:  ctrl.aluOp = aluAnd;
					fnOr:   ctrl.aluOp = aluOr;
					fnXor:  ctrl.aluOp = aluXor;
					fnNor:  ctrl.aluOp = aluNor;
					fnSlt:  ctrl.aluOp = aluSlt;
					fnSltu: ctrl.aluOp = aluSltu;
					fnJr: begin
						ctrl.regWrite = 1'b0;
						ctrl.destIsRd = 1'b0;
						ctrl.jump     = 1'b1;
						ctrl.jumpReg  = 1'b1;
					end
					fnJalr: begin
						ctrl.aluOp   = aluAddu;  // Return address pc+4 plus 4
						ctrl.jump    = 1'b1;
						ctrl.jumpReg = 1'b1;
						ctrl.link    = 1'b1;
					end
					default: unknown = 1'b1;
				endcase
			end

			opRegImm: begin
				ctrl.signExtImm = 1'b1;
				case (rtField)
					rtBltz:  ctrl.brCond = brLtz;
					rtBgez:  ctrl.brCond = brGez;
					default: unknown = 1'b1;
				endcase
			end

			opJ: ctrl.jump = 1'b1;
			opJal: begin
				ctrl.aluOp    = aluAddu;
				ctrl.regWrite = 1'b1;
				ctrl.jump     = 1'b1;
				ctrl.link     = 1'b1;
			end

			opBeq, opBne, opBlez, opBgtz: begin
				ctrl.signExtImm = 1'b1;
				case (opcode)
					opBeq:   ctrl.brCond = brEq;
					opBne:   ctrl.brCond = brNe;
					opBlez:  ctrl.brCond = brLez;
					default: ctrl.brCond = brGtz;
				endcase
			end

			// Immediate ALU group where logical ops zero extend
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.signExtImm = opcode inside {opAddi, opAddiu, opSlti, opSltiu};
				case (opcode)
					opAddi:  ctrl.aluOp = aluAdd;
					opAddiu: ctrl.aluOp = aluAddu;
					opSlti:  ctrl.aluOp = aluSlt;
					opSltiu: ctrl.aluOp = aluSltu;
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					opXori:  ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluLui;
				endcase
			end

			opLb, opLh, opLw, opLbu, opLhu: begin
				ctrl.aluOp       = aluAddu;  // Address = base + offset
				ctrl.regWrite    = 1'b1;
				ctrl.memRead     = 1'b1;
				ctrl.aluSrcImm   = 1'b1;
				ctrl.signExtImm  = 1'b1;
				ctrl.memUnsigned = opcode inside {opLbu, opLhu};
				if (opcode inside {opLb, opLbu}) begin
					ctrl.memSize = memByte;
				end else if (opcode inside {opLh, opLhu}) begin
					ctrl.memSize = memHalf;
				end
			end

			opSb, opSh, opSw: begin
				ctrl.aluOp      = aluAddu;
				ctrl.memWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.signExtImm = 1'b1;
				if (opcode == opSb) begin
					ctrl.memSize = memByte;
				end else if (opcode == opSh) begin
					ctrl.memSize = memHalf;
				end
			end

			default: unknown = 1'b1;
		endcase

		// Unknown encodings keep nothing but the flag
		if (unknown) begin
			ctrl         = '0;
			ctrl.illegal = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/pipeSlot.sv */
/* One-entry valid/ready register. Accepts while empty or while its content
   leaves in the same cycle, so upstream ready is combinational. */
`timescale 1ns/1ps
`default_nettype none

module pipeSlot #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     CLK,
	input  logic     RESET,
	input  logic     inValid,
	output logic     inReady,
	input  payload_t inData,
	output logic     outValid,
	input  logic     outReady,
	output payload_t outData
);

	logic     full;
	payload_t held;

	assign inReady  = !full || outReady;
	assign outValid = full;
	assign outData  = held;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			full <= 1'b0;
		end else if (inValid && inReady) begin
			full <= 1'b1;  // New item, or replacement of the leaving one
		end else if (outReady) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (inValid && inReady) begin
			held <= inData;
		end
	end

endmodule

`default_nettype wire

/* rtl/decodePkg.sv */
/* Shared widths, MIPS field encodings and packet types for the decode stage.
   Only the integer subset is encoded; COP1, HI/LO and unaligned accesses are absent. */
`default_nettype none

package decodePkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int numRegs      = 32;

	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [dataWidth-1:0]    word_t;

	////////////////////////////////////////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opRegImm  = 6'h01;  // Branch select in rt
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opBlez    = 6'h06;
	localparam logic [5:0] opBgtz    = 6'h07;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opSlti    = 6'h0a;
	localparam logic [5:0] opSltiu   = 6'h0b;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opXori    = 6'h0e;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLb      = 6'h20;
	localparam logic [5:0] opLh      = 6'h21;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opLbu     = 6'h24;
	localparam logic [5:0] opLhu     = 6'h25;
	localparam logic [5:0] opSb      = 6'h28;
	localparam logic [5:0] opSh      = 6'h29;
	localparam logic [5:0] opSw      = 6'h2b;

	// SPECIAL function codes, instr[5:0]
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnSllv = 6'h04;
	localparam logic [5:0] fnSrlv = 6'h06;
	localparam logic [5:0] fnSrav = 6'h07;
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnJalr = 6'h09;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// REGIMM selects, instr[20:16]
	localparam logic [4:0] rtBltz = 5'h00;
	localparam logic [4:0] rtBgez = 5'h01;

	localparam regAddr_t linkReg = 5'd31;  // JAL destination

	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav,
		aluLui
	} aluOp_t;

	typedef enum logic [1:0] {memByte, memHalf, memWord} memSize_t;

	typedef enum logic [2:0] {brNone, brEq, brNe, brLez, brGtz, brLtz, brGez} brCond_t;

	typedef struct packed {
		aluOp_t   aluOp;
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     memUnsigned;  // LBU/LHU
		logic     aluSrcImm;
		logic     signExtImm;
		logic     destIsRd;
		brCond_t  brCond;
		logic     jump;
		logic     jumpReg;      // Target from rs
		logic     link;
		logic     illegal;
	} decodeCtrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} fetchPacket_t;

	// One result bus from a later stage
	typedef struct packed {
		logic     enable;
		regAddr_t addr;
		word_t    data;
	} regWrite_t;

	typedef struct packed {
		word_t       pc;
		decodeCtrl_t ctrl;
		word_t       operandA;
		word_t       operandB;
		word_t       storeData;
		regAddr_t    destReg;
		logic [4:0]  shamt;
		logic        takenBranch;
		word_t       nextPc;
	} issuePacket_t;

endpackage

`default_nettype wire
